// ==== board_ctrl_top.f ====
board_id_pkg.sv
reg_bus_pkg.sv
cfg_ext_port.sv
ctrl_reg_port.sv
reg_bus_arbiter.sv
id_reg_bank.sv
led_heartbeat.sv
board_ctrl_top.sv
board_ctrl_props.sv
tb_board_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the board_ctrl_top testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_board_ctrl \
    -f board_ctrl_top.f -o sim_board_ctrl
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_board_ctrl 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1

// ==== tb_board_ctrl.sv ====
// Testbench for board_ctrl_top with LCG stimulus, register model, checks and watchdog
`timescale 1ns/1ps

module tb_board_ctrl import board_id_pkg::*; ();

localparam int mixed_txn   = 300;
localparam int batch_len   = 5;
localparam int hb_cycles   = 100;
localparam int txn_count   = 8 * 2 + 2 + 6 * 2 + 3 * 10 + mixed_txn;
localparam int watchdog_cyc = txn_count * 10 + hb_cycles;

logic        clk_125mhz = 1'b0;
logic        rst_125mhz = 1'b1;
logic        cfg_ext_read_received;
logic        cfg_ext_write_received;
logic [9:0]  cfg_ext_register_number;
logic [31:0] cfg_ext_write_data;
logic [31:0] cfg_ext_read_data;
logic        cfg_ext_read_data_valid;
logic        ctrl_req_valid;
logic        ctrl_req_ready;
logic        ctrl_req_write;
logic [9:0]  ctrl_req_addr;
logic [31:0] ctrl_req_wdata;
logic        ctrl_rsp_valid;
logic        ctrl_rsp_ready;
logic [31:0] ctrl_rsp_rdata;
logic [1:0]  sfp_los;
logic [3:0]  led;
logic [1:0]  sfp_led;
logic        led_hb;

// Model state
logic [3:0]  model_led;
logic        model_vpd_flag;
logic [14:0] model_vpd_addr;
logic [31:0] model_vpd_data;
logic [31:0] rng [3];
int          error_count = 0;

board_ctrl_top #(.hb_count(20)) board_ctrl_top_inst (.*);

always #4 clk_125mhz = !clk_125mhz;

// One LCG state per stimulus stream
function automatic logic [31:0] next_rand(input int stream);
    rng[stream] = rng[stream] * 32'd1664525 + 32'd1013904223;
    return rng[stream];
endfunction

function automatic logic [31:0] id_word(input logic [2:0] idx);
    case (idx)
        3'd0: return fpga_id;
        3'd1: return fw_id;
        3'd2: return fw_ver;
        3'd3: return board_id;
        3'd4: return board_ver;
        3'd5: return build_date;
        3'd6: return git_hash;
        default: return release_info;
    endcase
endfunction

function automatic logic [31:0] model_read(input logic [9:0] a);
    logic [31:0] v;
    v = '0;
    if (a < 10'h008) v = id_word(a[2:0]);
    else if (a == 10'h010) v = {28'b0, model_led};
    else if (a == 10'h011) v = {30'b0, sfp_los};
    else if (a == 10'h02C) v = {model_vpd_flag, model_vpd_addr, 8'h00, 8'h03};
    else if (a == 10'h02D) v = model_vpd_data;
    return v;
endfunction

// Mostly mapped words, sometimes anywhere in the space
function automatic logic [9:0] pick_addr(input logic [31:0] r);
    logic [3:0] k;
    k = 4'(r[19:16] % 12);
    if (r[31:29] < 3'd2) return r[25:16];
    if (k < 4'd8) return {7'b0, k[2:0]};
    case (k)
        4'd8: return 10'h010;
        4'd9: return 10'h011;
        4'd10: return 10'h02C;
        default: return 10'h02D;
    endcase
endfunction

task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
    error_count++;
    $display("FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
endtask

task automatic plain_error(input string what);
    error_count++;
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
endtask

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else value_error(name, got, exp);
endtask

task automatic cfg_access(input logic wr, input logic [9:0] a, input logic [31:0] d,
                          output logic [31:0] rdata);
    int n;
    @(posedge clk_125mhz);
    cfg_ext_read_received   <= !wr;
    cfg_ext_write_received  <= wr;
    cfg_ext_register_number <= a;
    cfg_ext_write_data      <= d;
    @(posedge clk_125mhz);
    cfg_ext_read_received  <= 1'b0;
    cfg_ext_write_received <= 1'b0;
    rdata = '0;
    n = 0;
    if (!wr) begin
        // Valid due 2 to 4 cycles after the strobe edge
        do begin
            @(negedge clk_125mhz);
            n++;
            assert (cfg_ext_read_data_valid || n < 5)
                else plain_error("cfg_ext read did not return within 4 cycles");
        end while (!cfg_ext_read_data_valid);
        rdata = cfg_ext_read_data;
    end
endtask

task automatic ctrl_access(input logic wr, input logic [9:0] a, input logic [31:0] d,
                           output logic [31:0] rdata);
    int          n;
    logic        seen;
    logic [31:0] r;
    @(posedge clk_125mhz);
    ctrl_req_valid <= 1'b1;
    ctrl_req_write <= wr;
    ctrl_req_addr  <= a;
    ctrl_req_wdata <= d;
    n = 0;
    do begin
        @(negedge clk_125mhz);
        n++;
        assert (n < 64) else plain_error("ctrl request never accepted");
    end while (!ctrl_req_ready);
    @(posedge clk_125mhz);
    ctrl_req_valid <= 1'b0;
    r = next_rand(2);
    ctrl_rsp_ready <= r[20];
    n = 0;
    seen = 1'b0;
    while (1) begin
        @(negedge clk_125mhz);
        n++;
        if (ctrl_rsp_valid) seen = 1'b1;
        assert (seen || n < 5) else plain_error("ctrl response later than 4 cycles");
        assert (n < 64) else plain_error("ctrl response never accepted");
        if (ctrl_rsp_valid && ctrl_rsp_ready) break;
        @(posedge clk_125mhz);
        r = next_rand(2);
        ctrl_rsp_ready <= |r[21:20];
    end
    rdata = ctrl_rsp_rdata;
endtask

task automatic cfg_stream(input int count);
    logic        wr;
    logic [9:0]  a;
    logic [31:0] d;
    logic [31:0] r;
    for (int i = 0; i < count; i++) begin
        r  = next_rand(1);
        wr = r[20];
        a  = pick_addr(next_rand(1));
        // LED and VPD state belong to the ctrl stream here
        if (a == 10'h010) a = 10'h011;
        if (wr && a == 10'h02C) wr = 1'b0;
        cfg_access(wr, a, next_rand(1), d);
        if (!wr) check_value("cfg_ext_read_data", d, model_read(a));
    end
endtask

task automatic ctrl_stream(input int count);
    logic        wr;
    logic [9:0]  a;
    logic [31:0] wd;
    logic [31:0] d;
    logic [31:0] r;
    for (int i = 0; i < count; i++) begin
        r  = next_rand(2);
        wr = r[22];
        a  = pick_addr(next_rand(2));
        wd = next_rand(2);
        if (wr && a == 10'h02C) a = 10'h010;
        ctrl_access(wr, a, wd, d);
        if (wr) begin
            check_value("ctrl_rsp_rdata", d, 32'h0);
            if (a == 10'h010) model_led = wd[3:0];
        end else begin
            check_value("ctrl_rsp_rdata", d, model_read(a));
        end
    end
endtask

task automatic reset_dut();
    @(posedge clk_125mhz);
    rst_125mhz <= 1'b1;
    repeat (2) @(posedge clk_125mhz);
    rst_125mhz <= 1'b0;
    model_led      = 4'hF;
    model_vpd_flag = 1'b0;
    model_vpd_addr = '0;
    model_vpd_data = '0;
endtask

initial begin
    repeat (watchdog_cyc) @(posedge clk_125mhz);
    $display("TEST FAILED");
    $fatal(1, "Timeout: the run did not finish in %0d cycles", watchdog_cyc);
end

initial begin
    logic [31:0] d;
    logic [31:0] v;
    logic [14:0] va;
    int          polls;
    cfg_ext_read_received   = 1'b0;
    cfg_ext_write_received  = 1'b0;
    cfg_ext_register_number = '0;
    cfg_ext_write_data      = '0;
    ctrl_req_valid          = 1'b0;
    ctrl_req_write          = 1'b0;
    ctrl_req_addr           = '0;
    ctrl_req_wdata          = '0;
    ctrl_rsp_ready          = 1'b0;
    sfp_los                 = 2'b00;
    rng[0] = 32'd33;
    rng[1] = next_rand(0);
    rng[2] = next_rand(0);
    reset_dut();

    // ID words and LED reset value on both ports
    for (int i = 0; i < 8; i++) begin
        cfg_access(1'b0, 10'(i), '0, d);
        check_value("cfg_ext_read_data", d, id_word(3'(i)));
        ctrl_access(1'b0, 10'(i), '0, d);
        check_value("ctrl_rsp_rdata", d, id_word(3'(i)));
    end
    cfg_access(1'b0, 10'h010, '0, d);
    check_value("cfg_ext_read_data", d, 32'hF);
    ctrl_access(1'b0, 10'h010, '0, d);
    check_value("ctrl_rsp_rdata", d, 32'hF);
    check_value("led", {28'b0, led}, 32'hF);

    // LED written on one port, read back on the other
    for (int i = 0; i < 6; i++) begin
        v = next_rand(0);
        model_led = v[3:0];
        if (i % 2 == 0) begin
            cfg_access(1'b1, 10'h010, v, d);
            ctrl_access(1'b0, 10'h010, '0, d);
            check_value("ctrl_rsp_rdata", d, {28'b0, model_led});
        end else begin
            ctrl_access(1'b1, 10'h010, v, d);
            cfg_access(1'b0, 10'h010, '0, d);
            check_value("cfg_ext_read_data", d, {28'b0, model_led});
        end
        check_value("led", {28'b0, led}, {28'b0, model_led});
    end

    // VPD read sequence
    for (int i = 0; i < 3; i++) begin
        va = 15'((next_rand(0) >> 16) % 8) << 2;
        ctrl_access(1'b1, 10'h02C, {1'b0, va, 16'h0}, d);
        polls = 0;
        do begin
            cfg_access(1'b0, 10'h02C, '0, v);
            polls++;
            assert (polls < 8) else plain_error("VPD flag never set after header write");
        end while (!v[31]);
        model_vpd_flag = 1'b1;
        model_vpd_addr = va;
        model_vpd_data = id_word(va[4:2]);
        check_value("cfg_ext_read_data", v, {1'b1, va, 8'h00, 8'h03});
        ctrl_access(1'b0, 10'h02D, '0, d);
        check_value("ctrl_rsp_rdata", d, model_vpd_data);
    end

    // Both ports at once, sfp_los fixed within a batch
    for (int b = 0; b < mixed_txn / (2 * batch_len); b++) begin
        @(posedge clk_125mhz);
        sfp_los <= 2'(next_rand(0) >> 16);
        @(negedge clk_125mhz);
        check_value("sfp_led", {30'b0, sfp_led}, {30'b0, sfp_los});
        fork
            cfg_stream(batch_len);
            ctrl_stream(batch_len);
        join
        check_value("led", {28'b0, led}, {28'b0, model_led});
    end

    // Heartbeat from reset, first toggle one edge after release
    reset_dut();
    for (int m = 0; m < hb_cycles - 10; m++) begin
        @(negedge clk_125mhz);
        v = (m == 0) ? 32'd1 : 32'(((m - 1) / 21) % 2);
        check_value("led_hb", {31'b0, led_hb}, v);
        check_value("sfp_led", {30'b0, sfp_led}, {30'b0, sfp_los});
        @(posedge clk_125mhz);
        sfp_los <= 2'(next_rand(0) >> 16);
    end

    if (error_count == 0) begin
        $display("TEST OK");
        $finish;
    end else begin
        $display("TEST FAILED");
        $fatal(1, "errors were found");
    end
end

endmodule

// ==== board_ctrl_props.sv ====
// Concurrent assertions for the board_ctrl_top handshakes, bound into the top level
`timescale 1ns/1ps

module board_ctrl_props (
    input logic        clk_125mhz,
    input logic        rst_125mhz,
    input logic        cfg_ext_read_received,
    input logic        cfg_ext_read_data_valid,
    input logic        ctrl_rsp_valid,
    input logic        ctrl_rsp_ready,
    input logic [31:0] ctrl_rsp_rdata,
    input logic [1:0]  req,
    input logic [1:0]  grant
);

// Reads issued by the host and not yet completed
logic [3:0] reads_open;

always_ff @(posedge clk_125mhz) begin
    reads_open <= reads_open + 4'(cfg_ext_read_received) - 4'(cfg_ext_read_data_valid);
    if (rst_125mhz) begin
        reads_open <= '0;
    end
end

read_valid_has_read: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
    cfg_ext_read_data_valid |-> reads_open != 0)
    else $error("cfg_ext read data valid without an outstanding read");

rsp_held_stable: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
    ctrl_rsp_valid && !ctrl_rsp_ready |=> ctrl_rsp_valid && $stable(ctrl_rsp_rdata))
    else $error("ctrl response changed while stalled");

// Contending ports are served one at a time and in turn
grants_exclusive: assert property (@(posedge clk_125mhz) disable iff (rst_125mhz)
    req == 2'b11 |=> $onehot(grant) && grant != $past(grant))
    else $error("contending ports not granted one at a time in turn");

idle_in_reset: assert property (@(posedge clk_125mhz)
    rst_125mhz |=> !ctrl_rsp_valid && !cfg_ext_read_data_valid)
    else $error("response valid during reset");

endmodule

bind board_ctrl_top board_ctrl_props board_ctrl_props_inst (
    .clk_125mhz(clk_125mhz),
    .rst_125mhz(rst_125mhz),
    .cfg_ext_read_received(cfg_ext_read_received),
    .cfg_ext_read_data_valid(cfg_ext_read_data_valid),
    .ctrl_rsp_valid(ctrl_rsp_valid),
    .ctrl_rsp_ready(ctrl_rsp_ready),
    .ctrl_rsp_rdata(ctrl_rsp_rdata),
    .req({bus_req_valid[1], bus_req_valid[0]}),
    .grant(bus_req_ready)
);

// ==== board_ctrl_top.sv ====
// Board management top level with register ports, arbiter, ID bank and LEDs
`timescale 1ns/1ps

module board_ctrl_top import reg_bus_pkg::*, board_id_pkg::*; #(
    parameter int unsigned hb_count = hb_count_default
) (
    input  logic                  clk_125mhz,
    input  logic                  rst_125mhz,

    input  logic                  cfg_ext_read_received,
    input  logic                  cfg_ext_write_received,
    input  logic [reg_addr_w-1:0] cfg_ext_register_number,
    input  logic [reg_data_w-1:0] cfg_ext_write_data,
    output logic [reg_data_w-1:0] cfg_ext_read_data,
    output logic                  cfg_ext_read_data_valid,

    input  logic                  ctrl_req_valid,
    output logic                  ctrl_req_ready,
    input  logic                  ctrl_req_write,
    input  logic [reg_addr_w-1:0] ctrl_req_addr,
    input  logic [reg_data_w-1:0] ctrl_req_wdata,
    output logic                  ctrl_rsp_valid,
    input  logic                  ctrl_rsp_ready,
    output logic [reg_data_w-1:0] ctrl_rsp_rdata,

    input  logic [sfp_count-1:0]  sfp_los,
    output logic [led_w-1:0]      led,
    output logic [sfp_count-1:0]  sfp_led,
    output logic                  led_hb
);

logic                  bus_req_valid [req_count];
logic                  bus_req_write [req_count];
logic [reg_addr_w-1:0] bus_req_addr  [req_count];
logic [reg_data_w-1:0] bus_req_wdata [req_count];
logic [req_count-1:0]  bus_req_ready;
logic [req_count-1:0]  bus_rsp_valid;
logic [reg_data_w-1:0] bus_rsp_rdata;

logic                  bank_valid;
logic                  bank_write;
logic [reg_addr_w-1:0] bank_addr;
logic [reg_data_w-1:0] bank_wdata;
logic [reg_data_w-1:0] bank_rdata;

// Requester 0
cfg_ext_port cfg_ext_port_inst (
    .clk_125mhz(clk_125mhz),
    .rst_125mhz(rst_125mhz),
    .cfg_ext_read_received(cfg_ext_read_received),
    .cfg_ext_write_received(cfg_ext_write_received),
    .cfg_ext_register_number(cfg_ext_register_number),
    .cfg_ext_write_data(cfg_ext_write_data),
    .cfg_ext_read_data(cfg_ext_read_data),
    .cfg_ext_read_data_valid(cfg_ext_read_data_valid),
    .bus_req_valid(bus_req_valid[0]),
    .bus_req_write(bus_req_write[0]),
    .bus_req_addr(bus_req_addr[0]),
    .bus_req_wdata(bus_req_wdata[0]),
    .bus_req_ready(bus_req_ready[0]),
    .bus_rsp_valid(bus_rsp_valid[0]),
    .bus_rsp_rdata(bus_rsp_rdata)
);

// Requester 1
ctrl_reg_port ctrl_reg_port_inst (
    .clk_125mhz(clk_125mhz),
    .rst_125mhz(rst_125mhz),
    .ctrl_req_valid(ctrl_req_valid),
    .ctrl_req_ready(ctrl_req_ready),
    .ctrl_req_write(ctrl_req_write),
    .ctrl_req_addr(ctrl_req_addr),
    .ctrl_req_wdata(ctrl_req_wdata),
    .ctrl_rsp_valid(ctrl_rsp_valid),
    .ctrl_rsp_ready(ctrl_rsp_ready),
    .ctrl_rsp_rdata(ctrl_rsp_rdata),
    .bus_req_valid(bus_req_valid[1]),
    .bus_req_write(bus_req_write[1]),
    .bus_req_addr(bus_req_addr[1]),
    .bus_req_wdata(bus_req_wdata[1]),
    .bus_req_ready(bus_req_ready[1]),
    .bus_rsp_valid(bus_rsp_valid[1]),
    .bus_rsp_rdata(bus_rsp_rdata)
);

reg_bus_arbiter reg_bus_arbiter_inst (
    .clk_125mhz(clk_125mhz),
    .rst_125mhz(rst_125mhz),
    .req_valid(bus_req_valid),
    .req_write(bus_req_write),
    .req_addr(bus_req_addr),
    .req_wdata(bus_req_wdata),
    .req_ready(bus_req_ready),
    .rsp_valid(bus_rsp_valid),
    .rsp_rdata(bus_rsp_rdata),
    .bank_valid(bank_valid),
    .bank_write(bank_write),
    .bank_addr(bank_addr),
    .bank_wdata(bank_wdata),
    .bank_rdata(bank_rdata)
);

id_reg_bank id_reg_bank_inst (
    .clk_125mhz(clk_125mhz),
    .rst_125mhz(rst_125mhz),
    .bank_valid(bank_valid),
    .bank_write(bank_write),
    .bank_addr(bank_addr),
    .bank_wdata(bank_wdata),
    .bank_rdata(bank_rdata),
    .sfp_los(sfp_los),
    .led(led)
);

led_heartbeat #(
    .hb_count(hb_count)
) led_heartbeat_inst (
    .clk_125mhz(clk_125mhz),
    .rst_125mhz(rst_125mhz),
    .sfp_los(sfp_los),
    .led_hb(led_hb),
    .sfp_led(sfp_led)
);

endmodule

// ==== led_heartbeat.sv ====
// Heartbeat LED down-counter and SFP link LED drive
`timescale 1ns/1ps

module led_heartbeat import reg_bus_pkg::*, board_id_pkg::*; #(
    parameter int unsigned hb_count = hb_count_default
) (
    input  logic                 clk_125mhz,
    input  logic                 rst_125mhz,

    input  logic [sfp_count-1:0] sfp_los,
    output logic                 led_hb,
    output logic [sfp_count-1:0] sfp_led
);

logic [$clog2(hb_count+1)-1:0] hb_cnt;
logic                          hb_reg;

// LED lit during reset, off after the first toggle
assign led_hb = !hb_reg;

// Lit while the link is down
assign sfp_led = sfp_los;

always_ff @(posedge clk_125mhz) begin
    if (hb_cnt == '0) begin
        hb_cnt <= hb_count[$bits(hb_cnt)-1:0];
        hb_reg <= !hb_reg;
    end else begin
        hb_cnt <= hb_cnt - 1'b1;
    end

    if (rst_125mhz) begin
        hb_cnt <= '0;
        hb_reg <= 1'b0;
    end
end

endmodule

// ==== id_reg_bank.sv ====
// Register decode with ID words, LED and SFP status registers and the VPD engine
`timescale 1ns/1ps

module id_reg_bank import reg_bus_pkg::*, board_id_pkg::*; (
    input  logic                  clk_125mhz,
    input  logic                  rst_125mhz,

    input  logic                  bank_valid,
    input  logic                  bank_write,
    input  logic [reg_addr_w-1:0] bank_addr,
    input  logic [reg_data_w-1:0] bank_wdata,
    output logic [reg_data_w-1:0] bank_rdata,

    input  logic [sfp_count-1:0]  sfp_los,
    output logic [led_w-1:0]      led
);

logic [led_w-1:0]      led_reg;
logic [vpd_addr_w-1:0] vpd_addr;
logic                  vpd_flag;
logic                  vpd_load;
logic [reg_data_w-1:0] vpd_data;

vpd_hdr_u hdr_wr;
vpd_hdr_u hdr_rd;

logic                  wr_en;
logic [reg_addr_w-1:0] id_off;
logic [reg_data_w-1:0] rd_mux;

assign led    = led_reg;
assign wr_en  = bank_valid && bank_write;
assign id_off = bank_addr - reg_addr_w'(reg_idx_id_base);

assign hdr_wr     = bank_wdata;
assign hdr_rd.raw = {vpd_flag, vpd_addr, vpd_cap_next, vpd_cap_id};

always_comb begin
    rd_mux = '0;
    if (id_off < reg_addr_w'(id_word_count)) begin
        rd_mux = id_words[id_off[id_idx_w-1:0]];
    end else begin
        case (bank_addr)
            reg_addr_w'(reg_idx_led):      rd_mux[led_w-1:0] = led_reg;
            reg_addr_w'(reg_idx_status):   rd_mux[sfp_count-1:0] = sfp_los;
            reg_addr_w'(reg_idx_vpd_hdr):  rd_mux = hdr_rd.raw;
            reg_addr_w'(reg_idx_vpd_data): rd_mux = vpd_data;
            default:                       rd_mux = '0;
        endcase
    end
end

always_ff @(posedge clk_125mhz) begin
    // Writes answer with zero
    bank_rdata <= (bank_valid && !bank_write) ? rd_mux : '0;

    // Fetch cycle of a VPD read
    if (vpd_load) begin
        vpd_data <= id_words[vpd_addr[id_idx_w+1:2]];
        vpd_flag <= 1'b1;
        vpd_load <= 1'b0;
    end

    if (wr_en && bank_addr == reg_addr_w'(reg_idx_led)) begin
        led_reg <= bank_wdata[led_w-1:0];
    end

    // Flag set on write means a VPD write, not supported
    if (wr_en && bank_addr == reg_addr_w'(reg_idx_vpd_hdr) && !hdr_wr.f.flag) begin
        vpd_addr <= hdr_wr.f.addr;
        vpd_flag <= 1'b0;
        vpd_load <= 1'b1;
    end

    if (rst_125mhz) begin
        led_reg  <= '1;
        vpd_addr <= '0;
        vpd_flag <= 1'b0;
        vpd_load <= 1'b0;
        vpd_data <= '0;
    end
end

endmodule

// ==== reg_bus_arbiter.sv ====
// Round-robin arbiter for the shared register bank and read data return
`timescale 1ns/1ps

module reg_bus_arbiter import reg_bus_pkg::*; (
    input  logic                  clk_125mhz,
    input  logic                  rst_125mhz,

    input  logic                  req_valid [req_count],
    input  logic                  req_write [req_count],
    input  logic [reg_addr_w-1:0] req_addr  [req_count],
    input  logic [reg_data_w-1:0] req_wdata [req_count],
    output logic [req_count-1:0]  req_ready,
    output logic [req_count-1:0]  rsp_valid,
    output logic [reg_data_w-1:0] rsp_rdata,

    output logic                  bank_valid,
    output logic                  bank_write,
    output logic [reg_addr_w-1:0] bank_addr,
    output logic [reg_data_w-1:0] bank_wdata,
    input  logic [reg_data_w-1:0] bank_rdata
);

logic                 grant_found;
logic [req_idx_w-1:0] grant_idx;
logic [req_idx_w-1:0] last_served;
logic                 inflight;

// Search starts one past the port served last
always_comb begin
    grant_found = 1'b0;
    grant_idx   = last_served;
    for (int k = 1; k <= req_count; k++) begin
        if (!grant_found && req_valid[(int'(last_served) + k) % req_count]) begin
            grant_found = 1'b1;
            grant_idx   = req_idx_w'((int'(last_served) + k) % req_count);
        end
    end
end

assign req_ready = grant_found ? (req_count'(1) << grant_idx) : '0;

assign bank_valid = grant_found;
assign bank_write = req_write[grant_idx];
assign bank_addr  = req_addr[grant_idx];
assign bank_wdata = req_wdata[grant_idx];

// Last-served pointer also names the owner of the access in flight
assign rsp_valid = inflight ? (req_count'(1) << last_served) : '0;
assign rsp_rdata = bank_rdata;

always_ff @(posedge clk_125mhz) begin
    inflight <= grant_found;
    if (grant_found) begin
        last_served <= grant_idx;
    end

    if (rst_125mhz) begin
        inflight <= 1'b0;
        // Port 0 first after reset
        last_served <= req_idx_w'(req_count - 1);
    end
end

endmodule

// ==== ctrl_reg_port.sv ====
// Control port with valid/ready handshakes, one request slot and a held response
`timescale 1ns/1ps

module ctrl_reg_port import reg_bus_pkg::*; (
    input  logic                  clk_125mhz,
    input  logic                  rst_125mhz,

    input  logic                  ctrl_req_valid,
    output logic                  ctrl_req_ready,
    input  logic                  ctrl_req_write,
    input  logic [reg_addr_w-1:0] ctrl_req_addr,
    input  logic [reg_data_w-1:0] ctrl_req_wdata,
    output logic                  ctrl_rsp_valid,
    input  logic                  ctrl_rsp_ready,
    output logic [reg_data_w-1:0] ctrl_rsp_rdata,

    output logic                  bus_req_valid,
    output logic                  bus_req_write,
    output logic [reg_addr_w-1:0] bus_req_addr,
    output logic [reg_data_w-1:0] bus_req_wdata,
    input  logic                  bus_req_ready,
    input  logic                  bus_rsp_valid,
    input  logic [reg_data_w-1:0] bus_rsp_rdata
);

logic                  req_held;
logic                  wait_rsp;
logic                  req_write_q;
logic [reg_addr_w-1:0] req_addr_q;
logic [reg_data_w-1:0] req_wdata_q;

// One transaction at a time, until the host takes the response
assign ctrl_req_ready = !(req_held || wait_rsp || ctrl_rsp_valid);

assign bus_req_valid = req_held;
assign bus_req_write = req_write_q;
assign bus_req_addr  = req_addr_q;
assign bus_req_wdata = req_wdata_q;

always_ff @(posedge clk_125mhz) begin
    if (ctrl_req_valid && ctrl_req_ready) begin
        req_held    <= 1'b1;
        req_write_q <= ctrl_req_write;
        req_addr_q  <= ctrl_req_addr;
        req_wdata_q <= ctrl_req_wdata;
    end

    if (req_held && bus_req_ready) begin
        req_held <= 1'b0;
        wait_rsp <= 1'b1;
    end

    // Bus is free again once the data sits in the response buffer
    if (wait_rsp && bus_rsp_valid) begin
        wait_rsp       <= 1'b0;
        ctrl_rsp_valid <= 1'b1;
        ctrl_rsp_rdata <= bus_rsp_rdata;
    end

    if (ctrl_rsp_valid && ctrl_rsp_ready) begin
        ctrl_rsp_valid <= 1'b0;
    end

    if (rst_125mhz) begin
        req_held       <= 1'b0;
        wait_rsp       <= 1'b0;
        ctrl_rsp_valid <= 1'b0;
    end
end

endmodule

// ==== cfg_ext_port.sv ====
// PCIe extended-config strobe capture, bus request queue and read completion
`timescale 1ns/1ps

module cfg_ext_port import reg_bus_pkg::*; (
    input  logic                  clk_125mhz,
    input  logic                  rst_125mhz,

    input  logic                  cfg_ext_read_received,
    input  logic                  cfg_ext_write_received,
    input  logic [reg_addr_w-1:0] cfg_ext_register_number,
    input  logic [reg_data_w-1:0] cfg_ext_write_data,
    output logic [reg_data_w-1:0] cfg_ext_read_data,
    output logic                  cfg_ext_read_data_valid,

    output logic                  bus_req_valid,
    output logic                  bus_req_write,
    output logic [reg_addr_w-1:0] bus_req_addr,
    output logic [reg_data_w-1:0] bus_req_wdata,
    input  logic                  bus_req_ready,
    input  logic                  bus_rsp_valid,
    input  logic [reg_data_w-1:0] bus_rsp_rdata
);

// Head entry drives the bus, skid entry absorbs a back-to-back write
logic                  head_valid;
logic                  head_write;
logic [reg_addr_w-1:0] head_addr;
logic [reg_data_w-1:0] head_wdata;
logic                  skid_valid;
logic                  skid_write;
logic [reg_addr_w-1:0] skid_addr;
logic [reg_data_w-1:0] skid_wdata;

logic strobe;
logic take;
logic rsp_is_read;

assign strobe = cfg_ext_read_received || cfg_ext_write_received;
assign take   = head_valid && bus_req_ready;

assign bus_req_valid = head_valid;
assign bus_req_write = head_write;
assign bus_req_addr  = head_addr;
assign bus_req_wdata = head_wdata;

always_ff @(posedge clk_125mhz) begin
    if (take) begin
        head_valid <= skid_valid;
        head_write <= skid_write;
        head_addr  <= skid_addr;
        head_wdata <= skid_wdata;
        skid_valid <= 1'b0;
    end

    if (strobe) begin
        if (!head_valid || (take && !skid_valid)) begin
            head_valid <= 1'b1;
            head_write <= cfg_ext_write_received;
            head_addr  <= cfg_ext_register_number;
            head_wdata <= cfg_ext_write_data;
        end else begin
            skid_valid <= 1'b1;
            skid_write <= cfg_ext_write_received;
            skid_addr  <= cfg_ext_register_number;
            skid_wdata <= cfg_ext_write_data;
        end
    end

    // Only reads complete towards the host
    rsp_is_read <= take && !head_write;
    cfg_ext_read_data_valid <= bus_rsp_valid && rsp_is_read;
    if (bus_rsp_valid && rsp_is_read) begin
        cfg_ext_read_data <= bus_rsp_rdata;
    end

    if (rst_125mhz) begin
        head_valid <= 1'b0;
        skid_valid <= 1'b0;
        rsp_is_read <= 1'b0;
        cfg_ext_read_data_valid <= 1'b0;
    end
end

endmodule

// ==== reg_bus_pkg.sv ====
// Register bus widths, requester count and the VPD header word type
package reg_bus_pkg;

localparam int reg_addr_w = 10;
localparam int reg_data_w = 32;

localparam int led_w     = 4;
localparam int sfp_count = 2;

// Peer ports sharing the register bank, 0 is cfg_ext
localparam int req_count = 2;
localparam int req_idx_w = $clog2(req_count);

localparam int vpd_addr_w = 15;

// VPD capability header, seen either as one word or as its fields
typedef union packed {
    logic [reg_data_w-1:0] raw;
    struct packed {
        logic                  flag;
        logic [vpd_addr_w-1:0] addr;
        logic [7:0]            next_ptr;
        logic [7:0]            cap_id;
    } f;
} vpd_hdr_u;

endpackage

// ==== board_id_pkg.sv ====
// Firmware and board ID words, register word map, VPD capability and heartbeat constants
package board_id_pkg;

// ID words, returned at words 0x00 to 0x07 in this order
localparam logic [31:0] fpga_id      = 32'h04A63093;
localparam logic [31:0] fw_id        = 32'h0000C001;
localparam logic [31:0] fw_ver       = 32'h000_01_000;
localparam logic [31:0] board_id     = 32'h1ded_0009;
localparam logic [31:0] board_ver    = 32'h001_00_000;
localparam logic [31:0] build_date   = 32'd602976000;
localparam logic [31:0] git_hash     = 32'h5f87c2e8;
localparam logic [31:0] release_info = 32'h00000000;

localparam int id_word_count = 8;
localparam int id_idx_w      = $clog2(id_word_count);

// Packed, so entry 0 is the rightmost word
localparam logic [id_word_count-1:0][31:0] id_words = {
    release_info, git_hash, build_date, board_ver,
    board_id, fw_ver, fw_id, fpga_id
};

// Word indices on the register bus
localparam int unsigned reg_idx_id_base  = 'h00;
localparam int unsigned reg_idx_led      = 'h10;
localparam int unsigned reg_idx_status   = 'h11;
localparam int unsigned reg_idx_vpd_hdr  = 'h2C;
localparam int unsigned reg_idx_vpd_data = 'h2D;

// VPD capability sits at byte offset 0xB0
localparam logic [7:0] vpd_cap_id   = 8'h03;
localparam logic [7:0] vpd_cap_next = 8'h00;

// Half period of the heartbeat at 125 MHz
localparam int unsigned hb_count_default = 62_500_000;

endpackage
